// File: Bender.yml
package:
  name: fxcvt

sources:
  - include_dirs:
      - common
    files:
      - common/fxcvt_pkg.sv
      - fixed_to_float/lead_zero_count.sv
      - fixed_to_float/fixed_to_float.sv
      - src/result_fifo.sv
      - src/axil_regs.sv
      - src/fxcvt_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_fxcvt.sv

// File: common/fxcvt_defines.svh
// defaults assume a signed integer input no wider than the 23-bit fraction and a power-of-two depth
`ifndef FXCVT_DEFINES_SVH
`define FXCVT_DEFINES_SVH

// converter widths
`define FXCVT_FIXED_WIDTH 12
`define FXCVT_EXP_WIDTH   8
`define FXCVT_MANT_WIDTH  23
`define FXCVT_EXP_BIAS    127

// result queue
`define FXCVT_FIFO_DEPTH  8

// AXI4-Lite bus and register offsets
`define FXCVT_ADDR_WIDTH  4
`define FXCVT_DATA_WIDTH  32
`define FXCVT_REG_DATA_IN 4'h0
`define FXCVT_REG_RESULT  4'h4
`define FXCVT_REG_STATUS  4'h8

`endif

// File: common/fxcvt_pkg.sv
// types only; the widths come from the macros of the shared defines header
`include "fxcvt_defines.svh"

package fxcvt_pkg;

    // converter datapath
    typedef logic signed [`FXCVT_FIXED_WIDTH-1:0] fixed_t;
    // one extra bit so the most negative input has a magnitude
    typedef logic [`FXCVT_FIXED_WIDTH:0] mag_t;
    typedef logic [$clog2(`FXCVT_FIXED_WIDTH+2)-1:0] lz_t;
    typedef logic [`FXCVT_EXP_WIDTH-1:0] exp_t;
    typedef logic [`FXCVT_MANT_WIDTH-1:0] mant_t;
    typedef logic [`FXCVT_EXP_WIDTH+`FXCVT_MANT_WIDTH:0] float_t;

    // bus words
    typedef logic [`FXCVT_ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [`FXCVT_DATA_WIDTH-1:0] axil_data_t;

    // occupancy 0 to depth inclusive
    typedef logic [$clog2(`FXCVT_FIFO_DEPTH+1)-1:0] fifo_count_t;

    // slave channel FSMs
    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_RESP
    } rd_state_t;

endpackage

// File: fixed_to_float/fixed_to_float.sv
// integer input only, bias fixed, exact for inputs up to the fraction width; no NaN, inf or denormals
`timescale 1ns/1ns
`include "fxcvt_defines.svh"

module fixed_to_float (
    input  logic               clk,
    input  logic               areset,
    input  logic               in_valid,
    input  fxcvt_pkg::fixed_t  in_data,
    output logic               out_valid,
    output fxcvt_pkg::float_t  out_float
);

    localparam int WIDE_W = `FXCVT_MANT_WIDTH + `FXCVT_FIXED_WIDTH + 1;

    // stage 1: sign and magnitude
    logic                  s1_valid;
    logic                  s1_sign;
    fxcvt_pkg::mag_t       s1_mag;

    // stage 2: leading-zero count
    logic                  s2_valid;
    logic                  s2_sign;
    logic                  s2_zero;
    fxcvt_pkg::mag_t       s2_mag;
    fxcvt_pkg::lz_t        s2_lz;

    logic signed [`FXCVT_FIXED_WIDTH:0] in_ext;
    fxcvt_pkg::lz_t        lz_count;
    logic                  lz_all_zero;
    logic [WIDE_W-1:0]     mant_wide;
    fxcvt_pkg::exp_t       exp_next;

    // sign extend first so -2^(n-1) negates without overflow
    assign in_ext = in_data;

    lead_zero_count i_lzc (
        .value    (s1_mag),
        .count    (lz_count),
        .all_zero (lz_all_zero)
    );

    // top set bit sits at FIXED_WIDTH - lz
    assign exp_next = fxcvt_pkg::exp_t'(`FXCVT_EXP_BIAS + `FXCVT_FIXED_WIDTH - s2_lz);

    // line the top set bit up just above the fraction field
    assign mant_wide = {{`FXCVT_MANT_WIDTH{1'b0}}, s2_mag}
                       << (`FXCVT_MANT_WIDTH - `FXCVT_FIXED_WIDTH + s2_lz);

    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    // datapath of stages 1 and 2
    always_ff @(posedge clk) begin
        s1_sign <= in_data[`FXCVT_FIXED_WIDTH-1];
        s1_mag  <= in_ext[`FXCVT_FIXED_WIDTH] ? fxcvt_pkg::mag_t'(-in_ext)
                                              : fxcvt_pkg::mag_t'(in_ext);
        s2_sign <= s1_sign;
        s2_mag  <= s1_mag;
        s2_lz   <= lz_count;
        s2_zero <= lz_all_zero;
    end

    // stage 3 output register
    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            out_float <= '0;
        end else if (s2_valid) begin
            if (s2_zero) begin
                // +0.0
                out_float <= '0;
            end else begin
                out_float <= {s2_sign, exp_next, mant_wide[`FXCVT_MANT_WIDTH-1:0]};
            end
        end
    end

    // fixed three-cycle latency, the slave's admission count relies on it
    a_latency: assert property (
        @(posedge clk) disable iff (areset)
        in_valid |-> ##3 out_valid
    );

endmodule

// File: fixed_to_float/lead_zero_count.sv
// purely combinational; a zero input reports the full magnitude width and sets all_zero
`timescale 1ns/1ns
`include "fxcvt_defines.svh"

module lead_zero_count (
    input  fxcvt_pkg::mag_t value,
    output fxcvt_pkg::lz_t  count,
    output logic            all_zero
);

    localparam int TOP = `FXCVT_FIXED_WIDTH;

    // scan upward, so the highest set bit wins
    always_comb begin
        count = fxcvt_pkg::lz_t'(TOP + 1);
        for (int i = 0; i <= TOP; i++) begin
            if (value[i]) begin
                count = fxcvt_pkg::lz_t'(TOP - i);
            end
        end
    end

    assign all_zero = (value == '0);

endmodule

// File: fxcvt_top.f
+incdir+common
common/fxcvt_pkg.sv
fixed_to_float/lead_zero_count.sv
fixed_to_float/fixed_to_float.sv
src/result_fifo.sv
src/axil_regs.sv
src/fxcvt_top.sv
testbench/tb_fxcvt.sv

// File: src/axil_regs.sv
// one outstanding read and write; strobes ignored; reads of offsets other than RESULT/STATUS give SLVERR
`timescale 1ns/1ns
`include "fxcvt_defines.svh"

module axil_regs (
    input  logic                   clk,
    input  logic                   areset,
    input  fxcvt_pkg::axil_addr_t  s_awaddr,
    input  logic                   s_awvalid,
    output logic                   s_awready,
    input  fxcvt_pkg::axil_data_t  s_wdata,
    input  logic                   s_wvalid,
    output logic                   s_wready,
    output logic [1:0]             s_bresp,
    output logic                   s_bvalid,
    input  logic                   s_bready,
    input  fxcvt_pkg::axil_addr_t  s_araddr,
    input  logic                   s_arvalid,
    output logic                   s_arready,
    output fxcvt_pkg::axil_data_t  s_rdata,
    output logic [1:0]             s_rresp,
    output logic                   s_rvalid,
    input  logic                   s_rready,
    output logic                   conv_valid,
    output fxcvt_pkg::fixed_t      conv_data,
    output logic                   pop,
    input  fxcvt_pkg::float_t      head,
    input  fxcvt_pkg::fifo_count_t count,
    input  logic                   empty,
    input  logic                   full
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam int         CONV_LATENCY = 3;

    fxcvt_pkg::wr_state_t  wr_state;
    fxcvt_pkg::rd_state_t  rd_state;

    logic                  wr_is_data;
    logic                  slot_free;
    logic                  wr_hs;
    logic [1:0]            in_flight;
    logic [CONV_LATENCY-1:0] conv_dly;
    logic                  land;
    logic [$bits(fxcvt_pkg::fifo_count_t):0] pending;

    logic                  ar_hs;
    logic                  r_hs;
    logic                  rd_pop_pending;
    logic                  rd_pop_next;
    logic [1:0]            rd_resp_next;
    fxcvt_pkg::axil_data_t rd_data_next;
    fxcvt_pkg::axil_data_t status_word;

    // write side, AW and W taken together
    assign wr_is_data = (s_awaddr == `FXCVT_REG_DATA_IN);
    assign pending    = count + in_flight;
    assign slot_free  = (pending < `FXCVT_FIFO_DEPTH);
    assign wr_hs      = (wr_state == fxcvt_pkg::WR_IDLE) && s_awvalid && s_wvalid
                        && (!wr_is_data || slot_free);
    assign s_awready  = wr_hs;
    assign s_wready   = wr_hs;
    assign s_bvalid   = (wr_state == fxcvt_pkg::WR_RESP);

    // a sample reaches the FIFO count one cycle after the converter output
    assign land = conv_dly[CONV_LATENCY-1];

    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            wr_state   <= fxcvt_pkg::WR_IDLE;
            conv_valid <= 1'b0;
            conv_dly   <= '0;
            in_flight  <= '0;
        end else begin
            case (wr_state)
                fxcvt_pkg::WR_IDLE: begin
                    if (wr_hs) begin
                        wr_state <= fxcvt_pkg::WR_RESP;
                    end
                end
                fxcvt_pkg::WR_RESP: begin
                    if (s_bready) begin
                        wr_state <= fxcvt_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= fxcvt_pkg::WR_IDLE;
            endcase
            conv_valid <= wr_hs && wr_is_data;
            conv_dly   <= {conv_dly[CONV_LATENCY-2:0], conv_valid};
            if (wr_hs && wr_is_data && !land) begin
                in_flight <= in_flight + 1'b1;
            end else if (land && !(wr_hs && wr_is_data)) begin
                in_flight <= in_flight - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            s_bresp   <= wr_is_data ? RESP_OKAY : RESP_SLVERR;
            conv_data <= fxcvt_pkg::fixed_t'(s_wdata[`FXCVT_FIXED_WIDTH-1:0]);
        end
    end

    // read side
    assign s_arready = (rd_state == fxcvt_pkg::RD_IDLE);
    assign s_rvalid  = (rd_state == fxcvt_pkg::RD_RESP);
    assign ar_hs     = s_arready && s_arvalid;
    assign r_hs      = s_rvalid && s_rready;
    // head stays put until this pop, only this slave pops
    assign pop       = r_hs && rd_pop_pending;

    always_comb begin
        status_word = '0;
        status_word[$bits(fxcvt_pkg::fifo_count_t)-1:0] = count;
        status_word[8] = empty;
        status_word[9] = full;
    end

    always_comb begin
        rd_data_next = '0;
        rd_resp_next = RESP_SLVERR;
        rd_pop_next  = 1'b0;
        case (s_araddr)
            `FXCVT_REG_RESULT: begin
                if (!empty) begin
                    rd_data_next = fxcvt_pkg::axil_data_t'(head);
                    rd_resp_next = RESP_OKAY;
                    rd_pop_next  = 1'b1;
                end
            end
            `FXCVT_REG_STATUS: begin
                rd_data_next = status_word;
                rd_resp_next = RESP_OKAY;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            rd_state       <= fxcvt_pkg::RD_IDLE;
            rd_pop_pending <= 1'b0;
        end else begin
            case (rd_state)
                fxcvt_pkg::RD_IDLE: begin
                    if (ar_hs) begin
                        rd_state       <= fxcvt_pkg::RD_RESP;
                        rd_pop_pending <= rd_pop_next;
                    end
                end
                fxcvt_pkg::RD_RESP: begin
                    if (s_rready) begin
                        rd_state       <= fxcvt_pkg::RD_IDLE;
                        rd_pop_pending <= 1'b0;
                    end
                end
                default: rd_state <= fxcvt_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            s_rdata <= rd_data_next;
            s_rresp <= rd_resp_next;
        end
    end

    // responses hold until accepted
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (areset)
        s_bvalid && !s_bready |=> s_bvalid
    );

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (areset)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata)
    );

    // FIFO head captured at AR must still be there at R
    a_pop_not_empty: assert property (
        @(posedge clk) disable iff (areset)
        pop |-> !empty
    );

endmodule

// File: src/fxcvt_top.sv
// AXI4-Lite converter peripheral; results are read back in write order from the RESULT register
`timescale 1ns/1ns
`include "fxcvt_defines.svh"

module fxcvt_top (
    input  logic                  clk,
    input  logic                  areset,
    input  fxcvt_pkg::axil_addr_t s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  fxcvt_pkg::axil_data_t s_wdata,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  fxcvt_pkg::axil_addr_t s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output fxcvt_pkg::axil_data_t s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready
);

    logic                   conv_valid;
    fxcvt_pkg::fixed_t      conv_data;
    logic                   out_valid;
    fxcvt_pkg::float_t      out_float;
    logic                   pop;
    fxcvt_pkg::float_t      head;
    fxcvt_pkg::fifo_count_t count;
    logic                   empty;
    logic                   full;

    axil_regs i_regs (
        .clk        (clk),
        .areset     (areset),
        .s_awaddr   (s_awaddr),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_wdata    (s_wdata),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_bresp    (s_bresp),
        .s_bvalid   (s_bvalid),
        .s_bready   (s_bready),
        .s_araddr   (s_araddr),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .s_rdata    (s_rdata),
        .s_rresp    (s_rresp),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .conv_valid (conv_valid),
        .conv_data  (conv_data),
        .pop        (pop),
        .head       (head),
        .count      (count),
        .empty      (empty),
        .full       (full)
    );

    fixed_to_float i_conv (
        .clk       (clk),
        .areset    (areset),
        .in_valid  (conv_valid),
        .in_data   (conv_data),
        .out_valid (out_valid),
        .out_float (out_float)
    );

    result_fifo #(
        .DEPTH (`FXCVT_FIFO_DEPTH)
    ) i_fifo (
        .clk       (clk),
        .areset    (areset),
        .push      (out_valid),
        .push_data (out_float),
        .pop       (pop),
        .head      (head),
        .count     (count),
        .empty     (empty),
        .full      (full)
    );

endmodule

// File: src/result_fifo.sv
// DEPTH must not exceed FXCVT_FIFO_DEPTH since count uses the shared width; push on full is dropped
`timescale 1ns/1ns
`include "fxcvt_defines.svh"

module result_fifo #(
    parameter int DEPTH = `FXCVT_FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   areset,
    input  logic                   push,
    input  fxcvt_pkg::float_t      push_data,
    input  logic                   pop,
    output fxcvt_pkg::float_t      head,
    output fxcvt_pkg::fifo_count_t count,
    output logic                   empty,
    output logic                   full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    fxcvt_pkg::float_t mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              wr_en;
    logic              rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;
    assign empty = (count == '0);
    assign full  = (count == fxcvt_pkg::fifo_count_t'(DEPTH));
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge areset) begin
        if (areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // upstream admission control must keep room for every result
    a_no_overflow: assert property (
        @(posedge clk) disable iff (areset)
        !(push && full)
    );

endmodule

// File: testbench/tb_fxcvt.sv
// directed tests of fxcvt_top; assumes the default 12-bit input, bias 127 and an 8-entry result FIFO
`timescale 1ns/1ns
`include "fxcvt_defines.svh"

module tb_fxcvt;

    localparam int         TIMEOUT     = 100;
    localparam int         DEPTH       = `FXCVT_FIFO_DEPTH;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                  clk;
    logic                  areset;
    fxcvt_pkg::axil_addr_t s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    fxcvt_pkg::axil_data_t s_wdata;
    logic                  s_wvalid;
    logic                  s_wready;
    logic [1:0]            s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    fxcvt_pkg::axil_addr_t s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    fxcvt_pkg::axil_data_t s_rdata;
    logic [1:0]            s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;

    integer                seed = 32'hcbad;
    // expected results in FIFO order
    fxcvt_pkg::float_t     exp_q[$];

    fxcvt_top i_dut (
        .clk       (clk),
        .areset    (areset),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            stop_run($sformatf("error at %0t ns: %s is %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    // sign, then exponent from the top set bit, then the bits below it as fraction
    function automatic fxcvt_pkg::float_t float_model(input fxcvt_pkg::fixed_t v);
        int          mag;
        int          top;
        logic        sign;
        logic [31:0] frac;
        sign = v[`FXCVT_FIXED_WIDTH-1];
        mag  = sign ? -int'(v) : int'(v);
        if (mag == 0) begin
            return '0;
        end
        top = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                top = i;
            end
        end
        frac = 32'(mag) << (`FXCVT_MANT_WIDTH - top);
        return {sign, fxcvt_pkg::exp_t'(`FXCVT_EXP_BIAS + top), frac[`FXCVT_MANT_WIDTH-1:0]};
    endfunction

    // AW and W are presented together and held until accepted
    task automatic start_write(input fxcvt_pkg::axil_addr_t addr,
                               input fxcvt_pkg::axil_data_t data);
        @(negedge clk);
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wvalid  = 1'b1;
    endtask

    // called at a falling edge; ready is stable one ns later
    task automatic wait_write_accept(input int limit, output logic accepted);
        int cycles;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted && cycles < limit) begin
            #1;
            if (s_awready && s_wready) begin
                accepted = 1'b1;
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        if (accepted) begin
            @(negedge clk);
            s_awvalid = 1'b0;
            s_wvalid  = 1'b0;
        end
    endtask

    task automatic finish_write(output logic [1:0] resp);
        int cycles;
        cycles   = 0;
        s_bready = 1'b1;
        #1;
        while (!s_bvalid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout waiting for bvalid");
            end
            @(negedge clk);
            #1;
        end
        resp = s_bresp;
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    task automatic axil_write(input fxcvt_pkg::axil_addr_t addr,
                              input fxcvt_pkg::axil_data_t data, output logic [1:0] resp);
        logic accepted;
        start_write(addr, data);
        wait_write_accept(TIMEOUT, accepted);
        if (!accepted) begin
            stop_run("timeout waiting for awready and wready");
        end
        finish_write(resp);
    endtask

    task automatic axil_read(input fxcvt_pkg::axil_addr_t addr,
                             output fxcvt_pkg::axil_data_t data, output logic [1:0] resp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        #1;
        while (!s_arready) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout waiting for arready");
            end
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        cycles    = 0;
        #1;
        while (!s_rvalid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("timeout waiting for rvalid");
            end
            @(negedge clk);
            #1;
        end
        data = s_rdata;
        resp = s_rresp;
        @(negedge clk);
        s_rready = 1'b0;
    endtask

    task automatic write_sample(input fxcvt_pkg::fixed_t v);
        logic [1:0] resp;
        axil_write(`FXCVT_REG_DATA_IN, fxcvt_pkg::axil_data_t'(v), resp);
        check_equal("DATA_IN write response", resp, RESP_OKAY);
        exp_q.push_back(float_model(v));
    endtask

    task automatic read_status(output int cnt, output logic emp, output logic ful);
        fxcvt_pkg::axil_data_t data;
        logic [1:0]            resp;
        axil_read(`FXCVT_REG_STATUS, data, resp);
        check_equal("STATUS read response", resp, RESP_OKAY);
        cnt = int'(data[$bits(fxcvt_pkg::fifo_count_t)-1:0]);
        emp = data[8];
        ful = data[9];
    endtask

    task automatic poll_count(input int expected);
        int   polls;
        int   cnt;
        logic emp;
        logic ful;
        polls = 0;
        read_status(cnt, emp, ful);
        while (cnt != expected) begin
            polls++;
            if (polls > TIMEOUT) begin
                stop_run($sformatf("timeout waiting for a result count of %0d", expected));
            end
            read_status(cnt, emp, ful);
        end
    endtask

    // pops the head and compares it with the oldest expected result
    task automatic pop_and_check();
        fxcvt_pkg::axil_data_t data;
        logic [1:0]            resp;
        fxcvt_pkg::float_t     expected;
        expected = exp_q.pop_front();
        axil_read(`FXCVT_REG_RESULT, data, resp);
        check_equal("RESULT read response", resp, RESP_OKAY);
        check_equal("RESULT data", data, 32'(expected));
    endtask

    task automatic test_status();
        int   cnt;
        logic emp;
        logic ful;
        read_status(cnt, emp, ful);
        check_equal("count after reset", cnt, 0);
        check_equal("empty after reset", emp, 1'b1);
        for (int i = 0; i < DEPTH; i++) begin
            write_sample(fxcvt_pkg::fixed_t'(i * 37 - 100));
        end
        poll_count(DEPTH);
        read_status(cnt, emp, ful);
        check_equal("full when filled", ful, 1'b1);
        check_equal("empty when filled", emp, 1'b0);
        for (int i = DEPTH - 1; i >= 0; i--) begin
            pop_and_check();
            read_status(cnt, emp, ful);
            check_equal("count after pop", cnt, i);
            check_equal("full after pop", ful, 1'b0);
        end
        check_equal("empty after draining", emp, 1'b1);
    endtask

    task automatic test_directed();
        fxcvt_pkg::fixed_t     vals [7];
        fxcvt_pkg::axil_data_t data;
        logic [1:0]            resp;
        vals = '{0, 1, -1, 2047, -2048, 5, -6};
        foreach (vals[i]) begin
            write_sample(vals[i]);
        end
        poll_count(7);
        // zero must come back as +0.0
        exp_q.delete(0);
        axil_read(`FXCVT_REG_RESULT, data, resp);
        check_equal("RESULT read response", resp, RESP_OKAY);
        check_equal("RESULT data for zero", data, 32'h0);
        repeat (6) pop_and_check();
    endtask

    task automatic test_random_stream();
        int sent;
        int burst;
        sent = 0;
        while (sent < 40) begin
            burst = ($unsigned($random(seed)) % DEPTH) + 1;
            if (burst > 40 - sent) begin
                burst = 40 - sent;
            end
            for (int i = 0; i < burst; i++) begin
                write_sample(fxcvt_pkg::fixed_t'($random(seed)));
            end
            poll_count(burst);
            repeat (burst) pop_and_check();
            sent += burst;
        end
    endtask

    task automatic test_back_pressure();
        logic       accepted;
        logic [1:0] resp;
        fxcvt_pkg::fixed_t extra;
        for (int i = 0; i < DEPTH; i++) begin
            write_sample(fxcvt_pkg::fixed_t'($random(seed)));
        end
        extra = fxcvt_pkg::fixed_t'($random(seed));
        start_write(`FXCVT_REG_DATA_IN, fxcvt_pkg::axil_data_t'(extra));
        wait_write_accept(20, accepted);
        assert (!accepted) else begin
            stop_run("a DATA_IN write was accepted while the FIFO had no free slot");
        end
        // one pop frees a slot for the stalled write
        pop_and_check();
        wait_write_accept(TIMEOUT, accepted);
        assert (accepted) else begin
            stop_run("the stalled DATA_IN write was not accepted after a pop");
        end
        finish_write(resp);
        check_equal("stalled write response", resp, RESP_OKAY);
        exp_q.push_back(float_model(extra));
        poll_count(DEPTH);
        repeat (DEPTH) pop_and_check();
    endtask

    task automatic test_errors();
        fxcvt_pkg::axil_data_t data;
        logic [1:0]            resp;
        int                    cnt;
        logic                  emp;
        logic                  ful;
        axil_read(`FXCVT_REG_RESULT, data, resp);
        check_equal("empty RESULT response", resp, RESP_SLVERR);
        check_equal("empty RESULT data", data, 32'h0);
        write_sample(fxcvt_pkg::fixed_t'(-321));
        poll_count(1);
        axil_write(`FXCVT_REG_STATUS, 32'h0000_0123, resp);
        check_equal("STATUS write response", resp, RESP_SLVERR);
        repeat (2) begin
            read_status(cnt, emp, ful);
            check_equal("count after STATUS write", cnt, 1);
        end
        pop_and_check();
    endtask

    initial begin
        areset    = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        areset = 1'b0;
        test_status();
        test_directed();
        test_random_stream();
        test_back_pressure();
        test_errors();
        $display("Test completed successfully");
        $finish;
    end

endmodule
